//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // datapath and instruction widths
    localparam int XLEN = 32;
    localparam int ILEN = 32;

    // instruction field positions
    localparam int OPC_LSB   = 2;
    localparam int OPC_MSB   = 6;
    localparam int F3_LSB    = 12;
    localparam int F3_MSB    = 14;
    localparam int IMM12_LSB = 20;
    localparam int IMM12_MSB = 31;

    // major opcode, bits 6:2 only
    localparam logic [4:0] OPC_SYSTEM = 5'b11100;

    // funct3 under SYSTEM
    localparam logic [2:0] F3_PRIV  = 3'b000;
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;
    localparam logic [2:0] F3_CSRRC = 3'b011;

    // bits 31:20 that separate the privileged forms
    localparam logic [11:0] IMM_ECALL = 12'h000;
    localparam logic [11:0] IMM_MRET  = 12'h302;

    // what the issue stage hands over
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [ILEN-1:0] instr;
        logic [XLEN-1:0] rs1_data;
    } fetch_t;

endpackage

//--- hw/csr_pkg.sv
package csr_pkg;

    typedef logic [11:0] csr_addr_t;

    // machine CSR addresses
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    // live mstatus bits
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    // MPP = 2'b11, machine mode only
    localparam logic [rv_isa_pkg::XLEN-1:0] MSTATUS_RESET = 32'h0000_1800;

    // environment call from M-mode
    localparam logic [rv_isa_pkg::XLEN-1:0] CAUSE_ECALL_M = 32'd11;

    typedef enum logic [2:0] {
        OP_RW    = 3'd0,
        OP_RS    = 3'd1,
        OP_RC    = 3'd2,
        OP_ECALL = 3'd3,
        OP_MRET  = 3'd4
    } csr_op_e;

    // decoder to CSR file
    typedef struct packed {
        csr_op_e                       op;
        csr_addr_t                     addr;
        logic [rv_isa_pkg::XLEN-1:0]   wdata;
        logic [rv_isa_pkg::XLEN-1:0]   pc;
    } csr_req_t;

    // rdata goes to rd, redirect/target go to fetch
    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0]   rdata;
        logic                          redirect;
        logic [rv_isa_pkg::XLEN-1:0]   target;
    } csr_rsp_t;

endpackage

//--- hw/sys_decode.sv
`timescale 1ns/10ps

module sys_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  rv_isa_pkg::fetch_t   in_i,
    output logic                 req_valid_o,
    input  logic                 req_ready_i,
    output csr_pkg::csr_req_t    req_o
);

    import rv_isa_pkg::*;
    import csr_pkg::*;

    logic [4:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] imm12;
    logic        keep;
    csr_op_e     op_d;
    csr_req_t    req_d;
    csr_req_t    req_q;
    logic        req_valid_q;

    assign opcode = in_i.instr[OPC_MSB:OPC_LSB];
    assign funct3 = in_i.instr[F3_MSB:F3_LSB];
    assign imm12  = in_i.instr[IMM12_MSB:IMM12_LSB];

    // classify, anything not recognised is dropped
    always_comb begin
        keep = 1'b0;
        op_d = OP_RW;
        if (opcode == OPC_SYSTEM) begin
            case (funct3)
                F3_CSRRW: begin
                    keep = 1'b1;
                    op_d = OP_RW;
                end
                F3_CSRRS: begin
                    keep = 1'b1;
                    op_d = OP_RS;
                end
                F3_CSRRC: begin
                    keep = 1'b1;
                    op_d = OP_RC;
                end
                F3_PRIV: begin
                    // ebreak and wfi fall through here
                    if (imm12 == IMM_ECALL) begin
                        keep = 1'b1;
                        op_d = OP_ECALL;
                    end else if (imm12 == IMM_MRET) begin
                        keep = 1'b1;
                        op_d = OP_MRET;
                    end
                end
                default: keep = 1'b0;
            endcase
        end
    end

    always_comb begin
        req_d.op    = op_d;
        req_d.addr  = imm12;
        req_d.wdata = in_i.rs1_data;
        req_d.pc    = in_i.pc;
    end

    // single output register, free when empty or draining
    assign in_ready_o = !req_valid_q || req_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid_q <= 1'b0;
        end else if (in_ready_o) begin
            req_valid_q <= in_valid_i && keep;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o && keep) begin
            req_q <= req_d;
        end
    end

    assign req_valid_o = req_valid_q;
    assign req_o       = req_q;

    // a stalled request must hold until taken
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_o)
    );

endmodule

//--- hw/req_fifo.sv
`timescale 1ns/10ps

module req_fifo #(
    parameter int  DEPTH = 4,
    parameter type T     = csr_pkg::csr_req_t
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid_i,
    output logic in_ready_o,
    input  T     in_i,
    output logic out_valid_o,
    input  logic out_ready_i,
    output T     out_o
);

    // DEPTH is a power of two, at least 2
    localparam int AW = $clog2(DEPTH);

    T             mem [DEPTH];
    logic [AW:0]  wr_ptr;
    logic [AW:0]  rd_ptr;
    logic         full;
    logic         empty;
    logic         push;
    logic         pop;

    // top bit is the wrap flag
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign in_ready_o  = !full;
    assign out_valid_o = !empty;

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= in_i;
        end
    end

    // head entry read straight from storage
    assign out_o = mem[rd_ptr[AW-1:0]];

    // writes only land while a slot is free
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> ((AW+1)'(wr_ptr - rd_ptr) < DEPTH)
    );

    // reads only while an entry is held
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> ((AW+1)'(wr_ptr - rd_ptr) inside {[1:DEPTH]})
    );

endmodule

//--- hw/csr_file.sv
`timescale 1ns/10ps

module csr_file (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  csr_pkg::csr_req_t   req_i,
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output csr_pkg::csr_rsp_t   rsp_o
);

    import rv_isa_pkg::*;
    import csr_pkg::*;

    // architectural state
    logic            mie_q;
    logic            mpie_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;

    logic [XLEN-1:0] mstatus_rd;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;

    logic            req_fire;
    logic            is_rw_op;
    logic            csr_we;
    logic            do_ecall;
    logic            do_mret;
    logic            wr_mstatus;
    logic            wr_mtvec;
    logic            wr_mepc;
    logic            wr_mcause;

    csr_rsp_t        rsp_d;
    csr_rsp_t        rsp_q;
    logic            rsp_valid_q;

    assign req_ready_o = !rsp_valid_q || rsp_ready_i;
    assign req_fire    = req_valid_i && req_ready_o;

    assign is_rw_op = (req_i.op == OP_RW) || (req_i.op == OP_RS) || (req_i.op == OP_RC);
    assign csr_we   = req_fire && is_rw_op;
    assign do_ecall = req_fire && (req_i.op == OP_ECALL);
    assign do_mret  = req_fire && (req_i.op == OP_MRET);

    assign wr_mstatus = csr_we && (req_i.addr == CSR_MSTATUS);
    assign wr_mtvec   = csr_we && (req_i.addr == CSR_MTVEC);
    assign wr_mepc    = csr_we && (req_i.addr == CSR_MEPC);
    assign wr_mcause  = csr_we && (req_i.addr == CSR_MCAUSE);

    // mstatus view, non-live fields read as reset value
    always_comb begin
        mstatus_rd               = MSTATUS_RESET;
        mstatus_rd[MSTATUS_MIE]  = mie_q;
        mstatus_rd[MSTATUS_MPIE] = mpie_q;
    end

    // unknown address reads zero
    always_comb begin
        case (req_i.addr)
            CSR_MSTATUS: old_val = mstatus_rd;
            CSR_MTVEC:   old_val = mtvec_q;
            CSR_MEPC:    old_val = mepc_q;
            CSR_MCAUSE:  old_val = mcause_q;
            default:     old_val = '0;
        endcase
    end

    always_comb begin
        case (req_i.op)
            OP_RW:   new_val = req_i.wdata;
            OP_RS:   new_val = old_val | req_i.wdata;
            OP_RC:   new_val = old_val & ~req_i.wdata;
            default: new_val = old_val;
        endcase
    end

    // MIE / MPIE stack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_q  <= MSTATUS_RESET[MSTATUS_MIE];
            mpie_q <= MSTATUS_RESET[MSTATUS_MPIE];
        end else if (do_ecall) begin
            mpie_q <= mie_q;
            mie_q  <= 1'b0;
        end else if (do_mret) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
        end else if (wr_mstatus) begin
            mie_q  <= new_val[MSTATUS_MIE];
            mpie_q <= new_val[MSTATUS_MPIE];
        end
    end

    // trap vector, word aligned
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q <= '0;
        end else if (wr_mtvec) begin
            mtvec_q <= {new_val[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_q <= '0;
        end else if (do_ecall) begin
            mepc_q <= {req_i.pc[XLEN-1:2], 2'b00};
        end else if (wr_mepc) begin
            mepc_q <= {new_val[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcause_q <= '0;
        end else if (do_ecall) begin
            mcause_q <= CAUSE_ECALL_M;
        end else if (wr_mcause) begin
            mcause_q <= new_val;
        end
    end

    // ecall jumps to mtvec, mret back to mepc
    always_comb begin
        rsp_d.rdata    = is_rw_op ? old_val : '0;
        rsp_d.redirect = (req_i.op == OP_ECALL) || (req_i.op == OP_MRET);
        rsp_d.target   = (req_i.op == OP_ECALL) ? mtvec_q : mepc_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else if (req_ready_o) begin
            rsp_valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

    // trap or return must come back as an aligned redirect
    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_fire && ((req_i.op == OP_ECALL) || (req_i.op == OP_MRET))
            |=> rsp_valid_o && rsp_o.redirect && (rsp_o.target[1:0] == 2'b00)
    );

endmodule

//--- hw/csr_subsys_top.sv
`timescale 1ns/10ps

module csr_subsys_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid_i,
    output logic                 instr_ready_o,
    input  rv_isa_pkg::fetch_t   instr_i,
    output logic                 rsp_valid_o,
    input  logic                 rsp_ready_i,
    output csr_pkg::csr_rsp_t    rsp_o
);

    import csr_pkg::*;

    // decoder to FIFO
    logic     dec_valid;
    logic     dec_ready;
    csr_req_t dec_req;

    // FIFO to CSR file
    logic     fifo_valid;
    logic     fifo_ready;
    csr_req_t fifo_req;

    sys_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (instr_valid_i),
        .in_ready_o  (instr_ready_o),
        .in_i        (instr_i),
        .req_valid_o (dec_valid),
        .req_ready_i (dec_ready),
        .req_o       (dec_req)
    );

    req_fifo #(
        .DEPTH (FIFO_DEPTH),
        .T     (csr_req_t)
    ) u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (dec_valid),
        .in_ready_o  (dec_ready),
        .in_i        (dec_req),
        .out_valid_o (fifo_valid),
        .out_ready_i (fifo_ready),
        .out_o       (fifo_req)
    );

    csr_file u_csr (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (fifo_valid),
        .req_ready_o (fifo_ready),
        .req_i       (fifo_req),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

endmodule

//--- verif/csr_tb.sv
`timescale 1ns/10ps

module csr_tb;

    import rv_isa_pkg::*;
    import csr_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int TIMEOUT   = 1000;
    localparam int N_STRETCH = 48;

    logic            clk;
    logic            rst_n;
    logic            instr_valid;
    logic            instr_ready;
    fetch_t          instr;
    logic            rsp_valid;
    logic            rsp_ready;
    csr_rsp_t        rsp;

    // trace contents, one entry per data line
    bit              t_exp    [MAX_LINES];
    fetch_t          t_fetch  [MAX_LINES];
    logic [XLEN-1:0] t_rdata  [MAX_LINES];
    logic            t_redir  [MAX_LINES];
    logic [XLEN-1:0] t_target [MAX_LINES];
    int              n_lines;

    // idle cycles before each instruction, then low/high stretches of rsp_ready
    int              gap      [MAX_LINES];
    int              bp_len   [N_STRETCH];
    int              seed;

    int              exp_q [$];
    int              errors;
    int              tests_run;
    int              rsp_count;
    int              exp_count;
    bit              saw_stall;

    csr_subsys_top #(
        .FIFO_DEPTH (4)
    ) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid),
        .instr_ready_o (instr_ready),
        .instr_i       (instr),
        .rsp_valid_o   (rsp_valid),
        .rsp_ready_i   (rsp_ready),
        .rsp_o         (rsp)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic load_trace;
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_exp;
        logic [31:0] f_pc;
        logic [31:0] f_instr;
        logic [31:0] f_rs1;
        logic [31:0] f_rdata;
        logic [31:0] f_redir;
        logic [31:0] f_target;
        n_lines = 0;
        exp_count = 0;
        fd = $fopen("verif/csr_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file verif/csr_trace.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            // comment and blank lines do not scan as seven numbers
            n = $sscanf(line, "%h %h %h %h %h %h %h",
                        f_exp, f_pc, f_instr, f_rs1, f_rdata, f_redir, f_target);
            if (n == 7) begin
                t_exp[n_lines]          = f_exp[0];
                t_fetch[n_lines].pc       = f_pc;
                t_fetch[n_lines].instr    = f_instr;
                t_fetch[n_lines].rs1_data = f_rs1;
                t_rdata[n_lines]        = f_rdata;
                t_redir[n_lines]        = f_redir[0];
                t_target[n_lines]       = f_target;
                if (f_exp[0]) begin
                    exp_count++;
                end
                n_lines++;
            end
        end
        $fclose(fd);
    endtask

    task automatic make_random;
        int i;
        for (i = 0; i < MAX_LINES; i++) begin
            gap[i] = 0;
            if (($random(seed) & 3) == 0) begin
                gap[i] = 1 + ($random(seed) & 1);
            end
        end
        // even entries hold rsp_ready low, odd ones release it
        for (i = 0; i < N_STRETCH; i++) begin
            if (i % 2 == 0) begin
                bp_len[i] = 8 + ($random(seed) & 15);
            end else begin
                bp_len[i] = 1 + ($random(seed) & 7);
            end
        end
    endtask

    task automatic apply_backpressure;
        int k;
        for (k = 0; k < N_STRETCH; k++) begin
            rsp_ready = (k % 2 == 1);
            repeat (bp_len[k]) begin
                @(posedge clk);
                #1;
            end
        end
        rsp_ready = 1'b1;
    endtask

    task automatic drive_instr(input int idx, output bit ok);
        int cycles;
        bit taken;
        cycles = 0;
        taken = 1'b0;
        ok = 1'b1;
        instr_valid = 1'b1;
        instr = t_fetch[idx];
        while (!taken && ok) begin
            // ready is settled by mid cycle, transfer happens on the next edge
            @(negedge clk);
            if (instr_ready) begin
                taken = 1'b1;
                if (t_exp[idx]) begin
                    exp_q.push_back(idx);
                end
            end
            @(posedge clk);
            #1;
            cycles++;
            if (!taken && cycles >= TIMEOUT) begin
                $display("timeout: line %0d was not accepted within %0d cycles", idx, TIMEOUT);
                ok = 1'b0;
            end
        end
        instr_valid = 1'b0;
    endtask

    task automatic wait_responses(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b1;
        while (exp_q.size() != 0 && ok) begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                $display("timeout: %0d responses still missing after %0d cycles",
                         exp_q.size(), TIMEOUT);
                ok = 1'b0;
            end
        end
    endtask

    task automatic check_rsp;
        int idx;
        bit good;
        rsp_count++;
        if (exp_q.size() == 0) begin
            $display("a response came at %0d ns while none was expected", $time);
            errors++;
            return;
        end
        idx = exp_q.pop_front();
        good = 1'b1;
        assert (rsp.rdata == t_rdata[idx]) else begin
            $display("Fail at %0d ns: line %0d rdata %h, expected %h",
                     $time, idx, rsp.rdata, t_rdata[idx]);
            good = 1'b0;
        end
        assert (rsp.redirect == t_redir[idx]) else begin
            $display("Fail at %0d ns: line %0d redirect %0b, expected %0b",
                     $time, idx, rsp.redirect, t_redir[idx]);
            good = 1'b0;
        end
        // target only means something on a redirect
        if (t_redir[idx]) begin
            assert (rsp.target == t_target[idx]) else begin
                $display("Fail at %0d ns: line %0d target %h, expected %h",
                         $time, idx, rsp.target, t_target[idx]);
                good = 1'b0;
            end
        end
        if (!good) begin
            errors++;
        end
        tests_run++;
        $display("test line %0d pc %h instr %h: %s", idx, t_fetch[idx].pc,
                 t_fetch[idx].instr, good ? "pass" : "fail");
    endtask

    // response handshakes, sampled mid cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (instr_valid && !instr_ready) begin
                saw_stall = 1'b1;
            end
            if (rsp_valid && rsp_ready) begin
                check_rsp();
            end
        end
    end

    initial begin : main
        int i;
        bit ok;
        seed = 51;
        errors = 0;
        tests_run = 0;
        rsp_count = 0;
        saw_stall = 1'b0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        rsp_ready = 1'b1;
        load_trace();
        make_random();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        tests_run++;
        assert (instr_ready && !rsp_valid) else begin
            $display("Fail at %0d ns: after reset instr_ready %0b rsp_valid %0b",
                     $time, instr_ready, rsp_valid);
            errors++;
        end
        $display("test reset handshake state: done");

        fork
            apply_backpressure();
        join_none

        ok = 1'b1;
        for (i = 0; i < n_lines && ok; i++) begin
            repeat (gap[i]) begin
                @(posedge clk);
                #1;
            end
            drive_instr(i, ok);
        end
        if (ok) begin
            wait_responses(ok);
        end
        if (!ok) begin
            errors++;
        end
        // a few more cycles to catch stray responses
        repeat (20) @(posedge clk);

        tests_run++;
        assert (rsp_count == exp_count) else begin
            $display("Fail at %0d ns: %0d responses, expected %0d",
                     $time, rsp_count, exp_count);
            errors++;
        end
        $display("test filtering: %0d responses for %0d lines", rsp_count, n_lines);

        tests_run++;
        assert (saw_stall) else begin
            $display("instr_ready never fell while the response side was stalled");
            errors++;
        end
        $display("test back-pressure: input stall seen %0b", saw_stall);

        $display("%0d tests, %0d responses, %0d errors", tests_run, rsp_count, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- verif/csr_trace.txt
# exp pc instr rs1_data | rdata redirect target, all hex
# exp = 1 when the line must produce a response, target checked on redirect only
1 00000100 300022f3 00000000 00001800 0 00000000  # read mstatus
1 00000104 305022f3 00000000 00000000 0 00000000  # read mtvec
1 00000108 341022f3 00000000 00000000 0 00000000  # read mepc
1 0000010c 342022f3 00000000 00000000 0 00000000  # read mcause
0 00000110 00100093 00000000 00000000 0 00000000  # addi
1 00000114 305312f3 00000403 00000000 0 00000000  # csrrw mtvec
1 00000118 305022f3 00000000 00000400 0 00000000
1 0000011c 300322f3 00000008 00001800 0 00000000  # set MIE
1 00000120 300022f3 00000000 00001808 0 00000000
0 00000124 00100073 00000000 00000000 0 00000000  # ebreak
1 00000128 00000073 00000000 00000000 1 00000400  # ecall
1 0000012c 341022f3 00000000 00000128 0 00000000
1 00000130 342022f3 00000000 0000000b 0 00000000
1 00000134 300022f3 00000000 00001880 0 00000000
0 00000138 10500073 00000000 00000000 0 00000000  # wfi
1 0000013c 341312f3 00000202 00000128 0 00000000  # csrrw mepc
1 00000140 30200073 00000000 00000000 1 00000200  # mret
1 00000144 300022f3 00000000 00001888 0 00000000
1 00000148 300332f3 00000088 00001888 0 00000000  # clear MIE and MPIE
1 0000014c 300022f3 00000000 00001800 0 00000000
1 00000150 342312f3 0000000f 0000000b 0 00000000
1 00000154 342332f3 00000003 0000000f 0 00000000  # csrrc mcause
1 00000158 342022f3 00000000 0000000c 0 00000000
0 0000015c 0002a303 00000000 00000000 0 00000000  # lw
1 00000160 7c0312f3 ffffffff 00000000 0 00000000  # unknown csr
1 00000164 7c0022f3 00000000 00000000 0 00000000
1 00000168 341322f3 00000013 00000200 0 00000000  # csrrs mepc
1 0000016c 341022f3 00000000 00000210 0 00000000
1 00000170 00000073 00000000 00000000 1 00000400  # ecall with MIE clear
1 00000174 300022f3 00000000 00001800 0 00000000
1 00000178 342022f3 00000000 0000000b 0 00000000
1 0000017c 30200073 00000000 00000000 1 00000170  # mret
1 00000180 300022f3 00000000 00001880 0 00000000
1 00000184 305322f3 0000000f 00000400 0 00000000  # csrrs mtvec
1 00000188 305022f3 00000000 0000040c 0 00000000

//--- flist.f
hw/rv_isa_pkg.sv
hw/csr_pkg.sv
hw/sys_decode.sv
hw/req_fifo.sv
hw/csr_file.sv
hw/csr_subsys_top.sv
verif/csr_tb.sv

//--- Makefile
# Verilator build and run of the CSR subsystem testbench

TOP = csr_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "simulation failed"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
